//--- src/mm_ram_pkg.sv
/*
 * shared definitions of the memory-mapped RAM wrapper
 * RAM geometry, bus widths, peripheral address map, status values,
 * timer interrupt id, access kind and peripheral register enums
 */
package mm_ram_pkg;

    // RAM geometry and bus widths
    localparam int RAM_ADDR_WIDTH    = 16;
    localparam int RAM_BYTES         = 2 ** RAM_ADDR_WIDTH;
    localparam int INSTR_RDATA_WIDTH = 128;
    localparam int DATA_WIDTH        = 32;
    localparam int BE_WIDTH          = 4;
    localparam int IRQ_ID_WIDTH      = 5;

    // byte offset bits inside a fetch line and inside a data word
    localparam int LINE_BYTES  = INSTR_RDATA_WIDTH / 8;
    localparam int LINE_OFFSET = $clog2(LINE_BYTES);
    localparam int WORD_OFFSET = $clog2(BE_WIDTH);

    // pseudo-peripheral registers, each at its own full address
    localparam logic [DATA_WIDTH-1:0] TIMER_MASK_ADDR  = 32'h1500_0000;
    localparam logic [DATA_WIDTH-1:0] TIMER_CNT_ADDR   = 32'h1500_0004;
    localparam logic [DATA_WIDTH-1:0] TEST_RESULT_ADDR = 32'h2000_0000;
    localparam logic [DATA_WIDTH-1:0] EXIT_ADDR        = 32'h2000_0004;

    // values the test software writes to report its result
    localparam logic [DATA_WIDTH-1:0] TEST_PASS_VALUE = 32'd123456789;
    localparam logic [DATA_WIDTH-1:0] TEST_FAIL_VALUE = 32'd1;

    // timer interrupt id, also the enabling bit of the timer mask
    localparam logic [IRQ_ID_WIDTH-1:0] TIMER_IRQ_ID = 5'd7;

    // what a data access targets
    typedef enum logic [1:0] {
        TXN_RAM,
        TXN_PER,
        TXN_ERR
    } txn_kind_e;

    // peripheral register selected by an access
    typedef enum logic [2:0] {
        REG_NONE,
        REG_TIMER_MASK,
        REG_TIMER_CNT,
        REG_TEST_RESULT,
        REG_EXIT
    } periph_reg_e;

endpackage

//--- src/dp_ram.sv
/*
 * dual-port byte-organised RAM
 * registered 128-bit instruction line read with its own grant and rvalid,
 * 32-bit data port with byte-enabled writes and registered reads
 */
`timescale 1ns/1ns

module dp_ram (
    input  logic                                        clk_i,
    input  logic                                        rst_ni,
    input  logic                                        instr_req_i,
    input  logic [mm_ram_pkg::RAM_ADDR_WIDTH-1:0]       instr_addr_i,
    output logic                                        instr_gnt_o,
    output logic                                        instr_rvalid_o,
    output logic [mm_ram_pkg::INSTR_RDATA_WIDTH-1:0]    instr_rdata_o,
    input  logic                                        ram_req_i,
    input  logic [mm_ram_pkg::RAM_ADDR_WIDTH-1:0]       ram_addr_i,
    input  logic                                        ram_we_i,
    input  logic [mm_ram_pkg::BE_WIDTH-1:0]             ram_be_i,
    input  logic [mm_ram_pkg::DATA_WIDTH-1:0]           ram_wdata_i,
    output logic [mm_ram_pkg::DATA_WIDTH-1:0]           ram_rdata_o
);

    logic [7:0] mem [mm_ram_pkg::RAM_BYTES];

    // no back-pressure on the fetch port
    assign instr_gnt_o = instr_req_i;

    // fetch the whole 16-byte line the address falls in
    always_ff @(posedge clk_i) begin
        if (instr_req_i) begin
            for (int i = 0; i < mm_ram_pkg::LINE_BYTES; i++) begin
                instr_rdata_o[8*i +: 8] <=
                    mem[{instr_addr_i[mm_ram_pkg::RAM_ADDR_WIDTH-1:mm_ram_pkg::LINE_OFFSET],
                         i[mm_ram_pkg::LINE_OFFSET-1:0]}];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            instr_rvalid_o <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_req_i;
        end
    end

    // data port works on the word the address falls in
    always_ff @(posedge clk_i) begin
        if (ram_req_i) begin
            for (int b = 0; b < mm_ram_pkg::BE_WIDTH; b++) begin
                if (ram_we_i && ram_be_i[b]) begin
                    mem[{ram_addr_i[mm_ram_pkg::RAM_ADDR_WIDTH-1:mm_ram_pkg::WORD_OFFSET],
                         b[mm_ram_pkg::WORD_OFFSET-1:0]}] <= ram_wdata_i[8*b +: 8];
                end else if (!ram_we_i) begin
                    ram_rdata_o[8*b +: 8] <=
                        mem[{ram_addr_i[mm_ram_pkg::RAM_ADDR_WIDTH-1:mm_ram_pkg::WORD_OFFSET],
                             b[mm_ram_pkg::WORD_OFFSET-1:0]}];
                end
            end
        end
    end

    // a store from the core always carries at least one byte
    a_write_has_bytes: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        ram_req_i && ram_we_i |-> ram_be_i != '0
    ) else $error("data write to %h with no byte enabled", ram_addr_i);

endmodule

//--- src/data_decoder.sv
/*
 * data address decoder
 * sends RAM accesses to the RAM data port, maps the named peripheral
 * addresses to a register select and marks the rest as unmapped
 */
`timescale 1ns/1ns

module data_decoder (
    input  logic                                    data_req_i,
    input  logic [mm_ram_pkg::DATA_WIDTH-1:0]       data_addr_i,
    input  logic                                    data_we_i,
    input  logic [mm_ram_pkg::BE_WIDTH-1:0]         data_be_i,
    input  logic [mm_ram_pkg::DATA_WIDTH-1:0]       data_wdata_i,
    output logic                                    ram_req_o,
    output logic [mm_ram_pkg::RAM_ADDR_WIDTH-1:0]   ram_addr_o,
    output logic                                    ram_we_o,
    output logic [mm_ram_pkg::BE_WIDTH-1:0]         ram_be_o,
    output logic [mm_ram_pkg::DATA_WIDTH-1:0]       ram_wdata_o,
    output mm_ram_pkg::periph_reg_e                 per_sel_o,
    output logic                                    per_we_o,
    output logic [mm_ram_pkg::DATA_WIDTH-1:0]       per_wdata_o,
    output mm_ram_pkg::txn_kind_e                   kind_o
);

    logic in_ram;

    // RAM sits at the bottom of the address space
    assign in_ram = data_addr_i[mm_ram_pkg::DATA_WIDTH-1:mm_ram_pkg::RAM_ADDR_WIDTH] == '0;

    always_comb begin
        ram_req_o = 1'b0;
        per_sel_o = mm_ram_pkg::REG_NONE;
        kind_o    = mm_ram_pkg::TXN_RAM;

        if (data_req_i) begin
            if (in_ram) begin
                ram_req_o = 1'b1;
            end else begin
                kind_o = mm_ram_pkg::TXN_PER;
                case (data_addr_i)
                    mm_ram_pkg::TIMER_MASK_ADDR: begin
                        per_sel_o = mm_ram_pkg::REG_TIMER_MASK;
                    end
                    mm_ram_pkg::TIMER_CNT_ADDR: begin
                        per_sel_o = mm_ram_pkg::REG_TIMER_CNT;
                    end
                    mm_ram_pkg::TEST_RESULT_ADDR: begin
                        per_sel_o = mm_ram_pkg::REG_TEST_RESULT;
                    end
                    mm_ram_pkg::EXIT_ADDR: begin
                        per_sel_o = mm_ram_pkg::REG_EXIT;
                    end
                    // unmapped, neither port sees it
                    default: begin
                        kind_o = mm_ram_pkg::TXN_ERR;
                    end
                endcase
            end
        end
    end

    // payload goes to both targets, the request or select qualifies it
    assign ram_addr_o  = data_addr_i[mm_ram_pkg::RAM_ADDR_WIDTH-1:0];
    assign ram_we_o    = data_we_i;
    assign ram_be_o    = data_be_i;
    assign ram_wdata_o = data_wdata_i;
    assign per_we_o    = data_we_i;
    assign per_wdata_o = data_wdata_i;

endmodule

//--- src/mmio_peripherals.sv
/*
 * pseudo-peripheral registers
 * countdown timer with maskable interrupt and acknowledge,
 * test-status and exit decode, registered read of mask and count
 */
`timescale 1ns/1ns

module mmio_peripherals (
    input  logic                                    clk_i,
    input  logic                                    rst_ni,
    input  mm_ram_pkg::periph_reg_e                 per_sel_i,
    input  logic                                    per_we_i,
    input  logic [mm_ram_pkg::DATA_WIDTH-1:0]       per_wdata_i,
    input  logic                                    irq_ack_i,
    input  logic [mm_ram_pkg::IRQ_ID_WIDTH-1:0]     irq_id_i,
    output logic [mm_ram_pkg::DATA_WIDTH-1:0]       per_rdata_o,
    output logic                                    irq_timer_o,
    output logic                                    tests_passed_o,
    output logic                                    tests_failed_o,
    output logic                                    exit_valid_o,
    output logic [mm_ram_pkg::DATA_WIDTH-1:0]       exit_value_o
);

    logic [mm_ram_pkg::DATA_WIDTH-1:0] timer_mask_q;
    logic [mm_ram_pkg::DATA_WIDTH-1:0] timer_cnt_q;
    logic                              irq_timer_q;
    logic                              mask_wr;
    logic                              cnt_wr;
    logic                              result_wr;
    logic                              irq_clear;

    assign mask_wr   = per_we_i && per_sel_i == mm_ram_pkg::REG_TIMER_MASK;
    assign cnt_wr    = per_we_i && per_sel_i == mm_ram_pkg::REG_TIMER_CNT;
    assign result_wr = per_we_i && per_sel_i == mm_ram_pkg::REG_TEST_RESULT;
    assign irq_clear = irq_ack_i && irq_id_i == mm_ram_pkg::TIMER_IRQ_ID;

    // count stops while any timer register is written
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            timer_mask_q <= '0;
            timer_cnt_q  <= '0;
            irq_timer_q  <= 1'b0;
        end else begin
            if (mask_wr) begin
                timer_mask_q <= per_wdata_i;
            end
            if (cnt_wr) begin
                timer_cnt_q <= per_wdata_i;
            end else if (!mask_wr && timer_cnt_q != '0) begin
                timer_cnt_q <= timer_cnt_q - 1'b1;
            end
            // acknowledge wins over a new expiry in the same cycle
            if (irq_clear) begin
                irq_timer_q <= 1'b0;
            end else if (!mask_wr && !cnt_wr && timer_cnt_q == 1 &&
                         timer_mask_q[mm_ram_pkg::TIMER_IRQ_ID]) begin
                irq_timer_q <= 1'b1;
            end
        end
    end

    assign irq_timer_o = irq_timer_q;

    // read data follows the request by one cycle like the RAM
    always_ff @(posedge clk_i) begin
        case (per_sel_i)
            mm_ram_pkg::REG_TIMER_MASK: per_rdata_o <= timer_mask_q;
            mm_ram_pkg::REG_TIMER_CNT:  per_rdata_o <= timer_cnt_q;
            default:                    per_rdata_o <= '0;
        endcase
    end

    assign tests_passed_o = result_wr && per_wdata_i == mm_ram_pkg::TEST_PASS_VALUE;
    assign tests_failed_o = result_wr && per_wdata_i == mm_ram_pkg::TEST_FAIL_VALUE;
    assign exit_valid_o   = per_we_i && per_sel_i == mm_ram_pkg::REG_EXIT;
    assign exit_value_o   = exit_valid_o ? per_wdata_i : '0;

    // the interrupt only comes with the mask bit still set and the count run out
    a_irq_needs_mask: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        $rose(irq_timer_o) |->
            timer_mask_q[mm_ram_pkg::TIMER_IRQ_ID] && timer_cnt_q == '0
    ) else $error("timer interrupt raised with its mask bit clear or its count not expired");

endmodule

//--- src/data_response.sv
/*
 * data port response stage
 * grants every request, remembers the kind of each granted access and
 * returns rvalid with RAM data, peripheral data or an error one cycle later
 */
`timescale 1ns/1ns

module data_response (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                data_req_i,
    input  mm_ram_pkg::txn_kind_e               kind_i,
    input  logic [mm_ram_pkg::DATA_WIDTH-1:0]   ram_rdata_i,
    input  logic [mm_ram_pkg::DATA_WIDTH-1:0]   per_rdata_i,
    output logic                                data_gnt_o,
    output logic                                data_rvalid_o,
    output logic [mm_ram_pkg::DATA_WIDTH-1:0]   data_rdata_o,
    output logic                                data_err_o
);

    logic                  rvalid_q;
    mm_ram_pkg::txn_kind_e kind_q;

    // every target answers in one cycle, so grant is the request
    assign data_gnt_o = data_req_i;

    // one stage is enough for one request per cycle in flight
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
            kind_q   <= mm_ram_pkg::TXN_RAM;
        end else begin
            rvalid_q <= data_req_i;
            if (data_req_i) begin
                kind_q <= kind_i;
            end
        end
    end

    assign data_rvalid_o = rvalid_q;

    always_comb begin
        data_rdata_o = '0;
        data_err_o   = 1'b0;
        if (rvalid_q) begin
            case (kind_q)
                mm_ram_pkg::TXN_RAM: begin
                    data_rdata_o = ram_rdata_i;
                end
                mm_ram_pkg::TXN_PER: begin
                    data_rdata_o = per_rdata_i;
                end
                // unmapped: error with zero data
                default: begin
                    data_err_o = 1'b1;
                end
            endcase
        end
    end

    // each response answers the request of the cycle before, error only if unmapped
    a_rvalid_after_grant: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        data_rvalid_o |-> $past(data_req_i) &&
            data_err_o == ($past(kind_i) == mm_ram_pkg::TXN_ERR)
    ) else $error("data response does not match the granted request one cycle before");

endmodule

//--- src/mm_ram.sv
/*
 * memory-mapped RAM wrapper for a RISC-V core
 * connects the data decoder, dual-port RAM, pseudo-peripherals
 * and data response stage to the core's instruction and data ports
 */
`timescale 1ns/1ns

module mm_ram (
    input  logic                                        clk_i,
    input  logic                                        rst_ni,
    input  logic                                        instr_req_i,
    input  logic [mm_ram_pkg::RAM_ADDR_WIDTH-1:0]       instr_addr_i,
    output logic [mm_ram_pkg::INSTR_RDATA_WIDTH-1:0]    instr_rdata_o,
    output logic                                        instr_rvalid_o,
    output logic                                        instr_gnt_o,
    input  logic                                        data_req_i,
    input  logic [mm_ram_pkg::DATA_WIDTH-1:0]           data_addr_i,
    input  logic                                        data_we_i,
    input  logic [mm_ram_pkg::BE_WIDTH-1:0]             data_be_i,
    input  logic [mm_ram_pkg::DATA_WIDTH-1:0]           data_wdata_i,
    output logic [mm_ram_pkg::DATA_WIDTH-1:0]           data_rdata_o,
    output logic                                        data_rvalid_o,
    output logic                                        data_gnt_o,
    output logic                                        data_err_o,
    input  logic [mm_ram_pkg::IRQ_ID_WIDTH-1:0]         irq_id_i,
    input  logic                                        irq_ack_i,
    output logic                                        irq_timer_o,
    output logic                                        tests_passed_o,
    output logic                                        tests_failed_o,
    output logic                                        exit_valid_o,
    output logic [mm_ram_pkg::DATA_WIDTH-1:0]           exit_value_o
);

    logic                                   ram_req;
    logic [mm_ram_pkg::RAM_ADDR_WIDTH-1:0]  ram_addr;
    logic                                   ram_we;
    logic [mm_ram_pkg::BE_WIDTH-1:0]        ram_be;
    logic [mm_ram_pkg::DATA_WIDTH-1:0]      ram_wdata;
    logic [mm_ram_pkg::DATA_WIDTH-1:0]      ram_rdata;
    mm_ram_pkg::periph_reg_e                per_sel;
    logic                                   per_we;
    logic [mm_ram_pkg::DATA_WIDTH-1:0]      per_wdata;
    logic [mm_ram_pkg::DATA_WIDTH-1:0]      per_rdata;
    mm_ram_pkg::txn_kind_e                  kind;

    data_decoder u_decoder (
        .data_req_i   (data_req_i),
        .data_addr_i  (data_addr_i),
        .data_we_i    (data_we_i),
        .data_be_i    (data_be_i),
        .data_wdata_i (data_wdata_i),
        .ram_req_o    (ram_req),
        .ram_addr_o   (ram_addr),
        .ram_we_o     (ram_we),
        .ram_be_o     (ram_be),
        .ram_wdata_o  (ram_wdata),
        .per_sel_o    (per_sel),
        .per_we_o     (per_we),
        .per_wdata_o  (per_wdata),
        .kind_o       (kind)
    );

    // the RAM owns the fetch stage, grant and rvalid included
    dp_ram u_ram (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .ram_req_i      (ram_req),
        .ram_addr_i     (ram_addr),
        .ram_we_i       (ram_we),
        .ram_be_i       (ram_be),
        .ram_wdata_i    (ram_wdata),
        .ram_rdata_o    (ram_rdata)
    );

    mmio_peripherals u_periph (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .per_sel_i      (per_sel),
        .per_we_i       (per_we),
        .per_wdata_i    (per_wdata),
        .irq_ack_i      (irq_ack_i),
        .irq_id_i       (irq_id_i),
        .per_rdata_o    (per_rdata),
        .irq_timer_o    (irq_timer_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

    data_response u_response (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .data_req_i    (data_req_i),
        .kind_i        (kind),
        .ram_rdata_i   (ram_rdata),
        .per_rdata_i   (per_rdata),
        .data_gnt_o    (data_gnt_o),
        .data_rvalid_o (data_rvalid_o),
        .data_rdata_o  (data_rdata_o),
        .data_err_o    (data_err_o)
    );

endmodule

//--- bench/tb_checks.svh
/*
 * typed compare tasks for data words, fetch lines, single bits
 * and access kinds, with the stop on the first error
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic stop_with_fail(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "run stopped at the first error");
endtask

task automatic word_eq(input string name, input logic [mm_ram_pkg::DATA_WIDTH-1:0] got,
                       input logic [mm_ram_pkg::DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
        stop_with_fail($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
endtask

task automatic line_eq(input string name,
                       input logic [mm_ram_pkg::INSTR_RDATA_WIDTH-1:0] got,
                       input logic [mm_ram_pkg::INSTR_RDATA_WIDTH-1:0] exp);
    if (got !== exp) begin
        stop_with_fail($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
endtask

task automatic bit_eq(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        stop_with_fail($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
endtask

task automatic kind_eq(input string name, input mm_ram_pkg::txn_kind_e got,
                       input mm_ram_pkg::txn_kind_e exp);
    if (got !== exp) begin
        stop_with_fail($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    end
endtask

`endif

//--- bench/tb_mm_ram.sv
/*
 * testbench for the memory-mapped RAM wrapper
 * clock, reset, LFSR stimulus, byte model of the RAM, timeout and directed tests
 */
`timescale 1ns/1ns

module tb_mm_ram;

    // the tests take about 200 cycles
    localparam int MAX_CYCLES = 600;

    logic         clk_i = 1'b0;
    logic         rst_ni, instr_req_i, data_req_i, data_we_i, irq_ack_i;
    logic         instr_gnt_o, instr_rvalid_o, data_gnt_o, data_rvalid_o, data_err_o;
    logic         irq_timer_o, tests_passed_o, tests_failed_o, exit_valid_o;
    logic [15:0]  instr_addr_i;
    logic [3:0]   data_be_i;
    logic [4:0]   irq_id_i;
    logic [31:0]  data_addr_i, data_wdata_i, data_rdata_o, exit_value_o;
    logic [127:0] instr_rdata_o;
    logic [7:0]   ref_mem [65536];
    logic [15:0]  lines [4];
    logic [31:0]  lfsr_q = 32'd73;
    int           cycle = 0;

    mm_ram dut (.*);

    always #10 clk_i = ~clk_i;

    `include "tb_checks.svh"

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            stop_with_fail($sformatf("timeout, tests still running after %0d cycles", cycle));
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 32'hA300_0000 : lfsr_q >> 1;
        end
        return v;
    endfunction

    function automatic logic [31:0] model_word(input logic [15:0] addr);
        return {ref_mem[{addr[15:2], 2'd3}], ref_mem[{addr[15:2], 2'd2}],
                ref_mem[{addr[15:2], 2'd1}], ref_mem[{addr[15:2], 2'd0}]};
    endfunction

    // one data access with grant, decode, status outputs and the one-cycle response checked
    task automatic access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                          input logic [31:0] wdata, input mm_ram_pkg::txn_kind_e kind,
                          output logic [31:0] rdata);
        @(posedge clk_i);
        data_req_i <= 1'b1;
        data_we_i <= we;
        data_addr_i <= addr;
        data_be_i <= be;
        data_wdata_i <= wdata;
        @(negedge clk_i);
        bit_eq("data_gnt_o", data_gnt_o, 1'b1);
        bit_eq("data_rvalid_o", data_rvalid_o, 1'b0);
        kind_eq("access kind", dut.kind, kind);
        bit_eq("tests_passed_o", tests_passed_o,
               we && addr == mm_ram_pkg::TEST_RESULT_ADDR && wdata == 32'd123456789);
        bit_eq("tests_failed_o", tests_failed_o,
               we && addr == mm_ram_pkg::TEST_RESULT_ADDR && wdata == 32'd1);
        bit_eq("exit_valid_o", exit_valid_o, we && addr == mm_ram_pkg::EXIT_ADDR);
        if (we && addr == mm_ram_pkg::EXIT_ADDR) word_eq("exit_value_o", exit_value_o, wdata);
        @(posedge clk_i);
        data_req_i <= 1'b0;
        @(negedge clk_i);
        bit_eq("data_rvalid_o", data_rvalid_o, 1'b1);
        bit_eq("data_err_o", data_err_o, kind == mm_ram_pkg::TXN_ERR);
        rdata = data_rdata_o;
    endtask

    task automatic ram_write(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] wdata);
        logic [31:0] rdata;
        access(1'b1, addr, be, wdata, mm_ram_pkg::TXN_RAM, rdata);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) ref_mem[{addr[15:2], b[1:0]}] = wdata[8*b +: 8];
        end
    endtask

    task automatic ram_read(input logic [31:0] addr);
        logic [31:0] rdata;
        access(1'b0, addr, 4'h0, 32'h0, mm_ram_pkg::TXN_RAM, rdata);
        word_eq("data_rdata_o", rdata, model_word(addr[15:0]));
    endtask

    // full word first so every byte of the line is known, then a partial merge
    task automatic write_and_read_words();
        logic [31:0] addr;
        logic [3:0]  be;
        for (int l = 0; l < 4; l++) begin
            lines[l] = 16'(take_bits(12)) << 4;
            for (int w = 0; w < 4; w++) begin
                addr = {16'h0, lines[l] + 16'(4 * w)};
                be = 4'(take_bits(4));
                if (be == 4'h0) be = 4'ha;
                ram_write(addr, 4'hf, take_bits(32));
                ram_write(addr, be, take_bits(32));
                ram_read(addr);
            end
        end
    endtask

    task automatic fetch_lines();
        logic [127:0] exp_line;
        for (int l = 0; l < 4; l++) begin
            for (int i = 0; i < 16; i++) exp_line[8*i +: 8] = ref_mem[lines[l] + 16'(i)];
            @(posedge clk_i);
            instr_req_i <= 1'b1;
            // offset inside the line must not matter
            instr_addr_i <= lines[l] | 16'(take_bits(4));
            @(negedge clk_i);
            bit_eq("instr_gnt_o", instr_gnt_o, 1'b1);
            @(posedge clk_i);
            instr_req_i <= 1'b0;
            @(negedge clk_i);
            bit_eq("instr_rvalid_o", instr_rvalid_o, 1'b1);
            line_eq("instr_rdata_o", instr_rdata_o, exp_line);
        end
    endtask

    task automatic read_back_to_back();
        for (int i = 0; i <= 4; i++) begin
            @(posedge clk_i);
            data_req_i <= i < 4;
            data_we_i <= 1'b0;
            data_addr_i <= {16'h0, lines[i % 4] + 16'(4 * (i % 4))};
            @(negedge clk_i);
            if (i > 0) begin
                bit_eq("data_rvalid_o", data_rvalid_o, 1'b1);
                word_eq("data_rdata_o", data_rdata_o,
                        model_word(lines[i - 1] + 16'(4 * (i - 1))));
            end
        end
        @(negedge clk_i);
        bit_eq("data_rvalid_o", data_rvalid_o, 1'b0);
    endtask

    task automatic run_timer();
        logic [31:0] rdata;
        int          wr_cycle;
        access(1'b1, mm_ram_pkg::TIMER_MASK_ADDR, 4'hf, 32'h80, mm_ram_pkg::TXN_PER, rdata);
        access(1'b0, mm_ram_pkg::TIMER_MASK_ADDR, 4'h0, 32'h0, mm_ram_pkg::TXN_PER, rdata);
        word_eq("timer mask", rdata, 32'h80);
        access(1'b1, mm_ram_pkg::TIMER_CNT_ADDR, 4'hf, 32'd10, mm_ram_pkg::TXN_PER, rdata);
        // count of 10 loaded at the last edge, expires on the tenth edge after it
        for (int j = 1; j <= 13; j++) begin
            @(negedge clk_i);
            bit_eq("irq_timer_o", irq_timer_o, j >= 10);
        end
        @(posedge clk_i);
        irq_ack_i <= 1'b1;
        irq_id_i <= 5'd7;
        @(posedge clk_i);
        irq_ack_i <= 1'b0;
        @(negedge clk_i);
        bit_eq("irq_timer_o", irq_timer_o, 1'b0);
        access(1'b1, mm_ram_pkg::TIMER_MASK_ADDR, 4'hf, 32'h0, mm_ram_pkg::TXN_PER, rdata);
        access(1'b1, mm_ram_pkg::TIMER_CNT_ADDR, 4'hf, 32'd20, mm_ram_pkg::TXN_PER, rdata);
        wr_cycle = cycle;
        for (int r = 0; r < 2; r++) begin
            access(1'b0, mm_ram_pkg::TIMER_CNT_ADDR, 4'h0, 32'h0, mm_ram_pkg::TXN_PER, rdata);
            // read sampled the count one edge before its response
            word_eq("timer count", rdata, 32'(20 - (cycle - 1 - wr_cycle)));
        end
        repeat (25) begin
            @(negedge clk_i);
            bit_eq("irq_timer_o", irq_timer_o, 1'b0);
        end
    endtask

    task automatic report_status();
        logic [31:0] rdata;
        access(1'b1, mm_ram_pkg::TEST_RESULT_ADDR, 4'hf, 32'd123456789,
               mm_ram_pkg::TXN_PER, rdata);
        access(1'b1, mm_ram_pkg::TEST_RESULT_ADDR, 4'hf, 32'd1, mm_ram_pkg::TXN_PER, rdata);
        access(1'b1, mm_ram_pkg::EXIT_ADDR, 4'hf, take_bits(32), mm_ram_pkg::TXN_PER, rdata);
    endtask

    // 0x0001_0010 would alias word 0x10 if the decoder dropped high bits
    task automatic probe_unmapped();
        logic [31:0] rdata;
        ram_write(32'h10, 4'hf, take_bits(32));
        access(1'b0, 32'h3000_0000, 4'h0, 32'h0, mm_ram_pkg::TXN_ERR, rdata);
        word_eq("data_rdata_o", rdata, 32'h0);
        access(1'b1, 32'h0001_0010, 4'hf, take_bits(32), mm_ram_pkg::TXN_ERR, rdata);
        access(1'b1, 32'h1500_0008, 4'hf, take_bits(32), mm_ram_pkg::TXN_ERR, rdata);
        ram_read(32'h10);
    endtask

    initial begin
        rst_ni = 1'b0;
        instr_req_i = 1'b0;
        instr_addr_i = '0;
        data_req_i = 1'b0;
        data_addr_i = '0;
        data_we_i = 1'b0;
        data_be_i = '0;
        data_wdata_i = '0;
        irq_ack_i = 1'b0;
        irq_id_i = '0;
        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;
        write_and_read_words();
        fetch_lines();
        read_back_to_back();
        run_timer();
        report_status();
        probe_unmapped();
        $display("** PASS **");
        $finish;
    end

endmodule

//--- sources.f
+incdir+bench
src/mm_ram_pkg.sv
src/dp_ram.sv
src/data_decoder.sv
src/mmio_peripherals.sv
src/data_response.sv
src/mm_ram.sv
bench/tb_mm_ram.sv

//--- Makefile
# Verilator build and run of the mm_ram testbench

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f sources.f --top-module tb_mm_ram -Mdir obj_dir
	obj_dir/Vtb_mm_ram

clean:
	rm -rf obj_dir
